// ==== hw/snp_pkg.sv ====
package snp_pkg;

    // bank side.
    localparam int num_requests = 4;
    localparam int reqs_bits = 2;

    // snoop request fields.
    localparam int addr_width = 26;
    localparam int req_tag_width = 8;

    // slot table geometry.
    localparam int snrq_size = 8;
    localparam int slot_bits = 3;

    // pending ack counter, holds 0 to num_requests.
    localparam int cnt_width = 3;

    // counter load value on allocation.
    localparam logic [cnt_width-1:0] cnt_init = cnt_width'(num_requests);

    // counter value of the last outstanding ack.
    localparam logic [cnt_width-1:0] cnt_last = cnt_width'(1);

endpackage

// ==== hw/snp_slot_table.sv ====
`timescale 1ns/10ps

module snp_slot_table (
    input  logic                               clk,
    input  logic                               rst,

    // allocation side.
    input  logic                               alloc,
    input  logic [snp_pkg::addr_width-1:0]     wr_addr,
    input  logic                               wr_invalidate,
    input  logic [snp_pkg::req_tag_width-1:0]  wr_tag,
    output logic [snp_pkg::slot_bits-1:0]      free_slot,
    output logic                               full,

    // lookup by slot number.
    input  logic [snp_pkg::slot_bits-1:0]      rd_slot,
    output logic [snp_pkg::addr_width-1:0]     rd_addr,
    output logic                               rd_invalidate,
    output logic [snp_pkg::req_tag_width-1:0]  rd_tag,

    // release side.
    input  logic                               release_en,
    input  logic [snp_pkg::slot_bits-1:0]      release_slot
);

    logic [snp_pkg::snrq_size-1:0] used;

    logic [snp_pkg::addr_width-1:0]    addr_mem [snp_pkg::snrq_size];
    logic                              inv_mem  [snp_pkg::snrq_size];
    logic [snp_pkg::req_tag_width-1:0] tag_mem  [snp_pkg::snrq_size];

    // lowest free entry wins.
    always_comb begin
        free_slot = '0;
        for (int i = snp_pkg::snrq_size - 1; i >= 0; i--) begin
            if (!used[i]) begin
                free_slot = i[snp_pkg::slot_bits-1:0];
            end
        end
    end

    assign full = &used;

    // occupancy bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            used <= '0;
        end else begin
            if (release_en) begin
                used[release_slot] <= 1'b0;
            end
            if (alloc) begin
                used[free_slot] <= 1'b1;
            end
        end
    end

    // payload storage.
    always_ff @(posedge clk) begin
        if (alloc) begin
            addr_mem[free_slot] <= wr_addr;
            inv_mem[free_slot]  <= wr_invalidate;
            tag_mem[free_slot]  <= wr_tag;
        end
    end

    assign rd_addr       = addr_mem[rd_slot];
    assign rd_invalidate = inv_mem[rd_slot];
    assign rd_tag        = tag_mem[rd_slot];

endmodule

// ==== hw/snp_ack_arbiter.sv ====
`timescale 1ns/10ps

module snp_ack_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [snp_pkg::num_requests-1:0]  requests,
    input  logic                              ack_fire,
    output logic [snp_pkg::reqs_bits-1:0]     grant_index,
    output logic                              grant_valid
);

    // last accepted bank.
    logic [snp_pkg::reqs_bits-1:0] ptr;

    // grant that was offered but not taken.
    logic                          hold_valid;
    logic [snp_pkg::reqs_bits-1:0] hold_index;

    logic [snp_pkg::reqs_bits-1:0] rr_index;

    // search starts at the bank after ptr, ptr itself comes last.
    always_comb begin
        logic [snp_pkg::reqs_bits-1:0] idx;
        rr_index = ptr;
        for (int k = snp_pkg::num_requests; k >= 1; k--) begin
            idx = ptr + k[snp_pkg::reqs_bits-1:0];
            if (requests[idx]) begin
                rr_index = idx;
            end
        end
    end

    assign grant_index = hold_valid ? hold_index : rr_index;
    assign grant_valid = requests[grant_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr        <= '0;
            hold_valid <= 1'b0;
            hold_index <= '0;
        end else if (ack_fire) begin
            ptr        <= grant_index;
            hold_valid <= 1'b0;
        end else if (grant_valid) begin
            // stalled grant stays put until accepted.
            hold_valid <= 1'b1;
            hold_index <= grant_index;
        end
    end

endmodule

// ==== hw/snp_forwarder.sv ====
`timescale 1ns/10ps

module snp_forwarder (
    input  logic clk,
    input  logic rst,

    // snoop request from memory side.
    input  logic                                snp_req_valid,
    input  logic [snp_pkg::addr_width-1:0]      snp_req_addr,
    input  logic                                snp_req_invalidate,
    input  logic [snp_pkg::req_tag_width-1:0]   snp_req_tag,
    output logic                                snp_req_ready,

    // snoop response to memory side.
    output logic                                snp_rsp_valid,
    output logic [snp_pkg::addr_width-1:0]      snp_rsp_addr,
    output logic                                snp_rsp_invalidate,
    output logic [snp_pkg::req_tag_width-1:0]   snp_rsp_tag,
    input  logic                                snp_rsp_ready,

    // broadcast to banks.
    output logic [snp_pkg::num_requests-1:0]                            fwd_valid,
    output logic [snp_pkg::num_requests-1:0][snp_pkg::addr_width-1:0]   fwd_addr,
    output logic [snp_pkg::num_requests-1:0]                            fwd_invalidate,
    output logic [snp_pkg::num_requests-1:0][snp_pkg::slot_bits-1:0]    fwd_tag,
    input  logic [snp_pkg::num_requests-1:0]                            fwd_ready,

    // acks from banks.
    input  logic [snp_pkg::num_requests-1:0]                            ack_valid,
    input  logic [snp_pkg::num_requests-1:0][snp_pkg::slot_bits-1:0]    ack_tag,
    output logic [snp_pkg::num_requests-1:0]                            ack_ready,

    // arbiter.
    input  logic [snp_pkg::reqs_bits-1:0]       grant_index,
    input  logic                                grant_valid,
    output logic                                ack_fire,

    // slot table.
    input  logic [snp_pkg::slot_bits-1:0]       free_slot,
    input  logic                                full,
    input  logic [snp_pkg::addr_width-1:0]      rd_addr,
    input  logic                                rd_invalidate,
    input  logic [snp_pkg::req_tag_width-1:0]   rd_tag,
    output logic                                alloc,
    output logic                                release_en,
    output logic [snp_pkg::slot_bits-1:0]       rd_slot,
    output logic [snp_pkg::slot_bits-1:0]       release_slot
);

    // acks still expected per slot.
    logic [snp_pkg::cnt_width-1:0] pending_cnt [snp_pkg::snrq_size];

    logic                          all_fwd_ready;
    logic                          req_fire;
    logic                          sel_valid;
    logic [snp_pkg::slot_bits-1:0] sel_tag;
    logic [snp_pkg::cnt_width-1:0] sel_cnt;
    logic                          sel_last;
    logic                          sel_ready;

    // all-or-nothing broadcast.
    assign all_fwd_ready = &fwd_ready;
    assign snp_req_ready = !full && all_fwd_ready;
    assign req_fire      = snp_req_valid && snp_req_ready;
    assign alloc         = req_fire;

    always_comb begin
        for (int b = 0; b < snp_pkg::num_requests; b++) begin
            fwd_valid[b]      = req_fire;
            fwd_addr[b]       = snp_req_addr;
            fwd_invalidate[b] = snp_req_invalidate;
            fwd_tag[b]        = free_slot;
        end
    end

    // granted ack and its slot.
    assign sel_tag   = ack_tag[grant_index];
    assign sel_valid = grant_valid && ack_valid[grant_index];
    assign sel_cnt   = pending_cnt[sel_tag];
    assign sel_last  = (sel_cnt == snp_pkg::cnt_last);

    // final ack only goes through together with the response.
    assign sel_ready = !sel_last || snp_rsp_ready;
    assign ack_fire  = sel_valid && sel_ready;

    always_comb begin
        ack_ready              = '0;
        ack_ready[grant_index] = sel_valid && sel_ready;
    end

    assign rd_slot            = sel_tag;
    assign snp_rsp_valid      = sel_valid && sel_last;
    assign snp_rsp_addr       = rd_addr;
    assign snp_rsp_invalidate = rd_invalidate;
    assign snp_rsp_tag        = rd_tag;

    // slot is freed on the response transfer.
    assign release_en   = snp_rsp_valid && snp_rsp_ready;
    assign release_slot = sel_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < snp_pkg::snrq_size; i++) begin
                pending_cnt[i] <= '0;
            end
        end else begin
            if (req_fire) begin
                pending_cnt[free_slot] <= snp_pkg::cnt_init;
            end
            // never the same slot as the allocation.
            if (ack_fire) begin
                pending_cnt[sel_tag] <= sel_cnt - snp_pkg::cnt_last;
            end
        end
    end

endmodule

// ==== hw/snp_fwd_top.sv ====
`timescale 1ns/10ps

module snp_fwd_top (
    input  logic clk,
    input  logic rst,

    input  logic                                snp_req_valid,
    input  logic [snp_pkg::addr_width-1:0]      snp_req_addr,
    input  logic                                snp_req_invalidate,
    input  logic [snp_pkg::req_tag_width-1:0]   snp_req_tag,
    output logic                                snp_req_ready,

    output logic                                snp_rsp_valid,
    output logic [snp_pkg::addr_width-1:0]      snp_rsp_addr,
    output logic                                snp_rsp_invalidate,
    output logic [snp_pkg::req_tag_width-1:0]   snp_rsp_tag,
    input  logic                                snp_rsp_ready,

    output logic [snp_pkg::num_requests-1:0]                            fwd_valid,
    output logic [snp_pkg::num_requests-1:0][snp_pkg::addr_width-1:0]   fwd_addr,
    output logic [snp_pkg::num_requests-1:0]                            fwd_invalidate,
    output logic [snp_pkg::num_requests-1:0][snp_pkg::slot_bits-1:0]    fwd_tag,
    input  logic [snp_pkg::num_requests-1:0]                            fwd_ready,

    input  logic [snp_pkg::num_requests-1:0]                            ack_valid,
    input  logic [snp_pkg::num_requests-1:0][snp_pkg::slot_bits-1:0]    ack_tag,
    output logic [snp_pkg::num_requests-1:0]                            ack_ready
);

    logic                              alloc;
    logic                              release_en;
    logic [snp_pkg::slot_bits-1:0]     rd_slot;
    logic [snp_pkg::slot_bits-1:0]     release_slot;
    logic [snp_pkg::slot_bits-1:0]     free_slot;
    logic                              full;
    logic [snp_pkg::addr_width-1:0]    rd_addr;
    logic                              rd_invalidate;
    logic [snp_pkg::req_tag_width-1:0] rd_tag;
    logic [snp_pkg::reqs_bits-1:0]     grant_index;
    logic                              grant_valid;
    logic                              ack_fire;

    snp_forwarder u_snp_forwarder (
        .clk                (clk),
        .rst                (rst),
        .snp_req_valid      (snp_req_valid),
        .snp_req_addr       (snp_req_addr),
        .snp_req_invalidate (snp_req_invalidate),
        .snp_req_tag        (snp_req_tag),
        .snp_req_ready      (snp_req_ready),
        .snp_rsp_valid      (snp_rsp_valid),
        .snp_rsp_addr       (snp_rsp_addr),
        .snp_rsp_invalidate (snp_rsp_invalidate),
        .snp_rsp_tag        (snp_rsp_tag),
        .snp_rsp_ready      (snp_rsp_ready),
        .fwd_valid          (fwd_valid),
        .fwd_addr           (fwd_addr),
        .fwd_invalidate     (fwd_invalidate),
        .fwd_tag            (fwd_tag),
        .fwd_ready          (fwd_ready),
        .ack_valid          (ack_valid),
        .ack_tag            (ack_tag),
        .ack_ready          (ack_ready),
        .grant_index        (grant_index),
        .grant_valid        (grant_valid),
        .ack_fire           (ack_fire),
        .free_slot          (free_slot),
        .full               (full),
        .rd_addr            (rd_addr),
        .rd_invalidate      (rd_invalidate),
        .rd_tag             (rd_tag),
        .alloc              (alloc),
        .release_en         (release_en),
        .rd_slot            (rd_slot),
        .release_slot       (release_slot)
    );

    snp_slot_table u_snp_slot_table (
        .clk           (clk),
        .rst           (rst),
        .alloc         (alloc),
        .wr_addr       (snp_req_addr),
        .wr_invalidate (snp_req_invalidate),
        .wr_tag        (snp_req_tag),
        .free_slot     (free_slot),
        .full          (full),
        .rd_slot       (rd_slot),
        .rd_addr       (rd_addr),
        .rd_invalidate (rd_invalidate),
        .rd_tag        (rd_tag),
        .release_en    (release_en),
        .release_slot  (release_slot)
    );

    snp_ack_arbiter u_snp_ack_arbiter (
        .clk         (clk),
        .rst         (rst),
        .requests    (ack_valid),
        .ack_fire    (ack_fire),
        .grant_index (grant_index),
        .grant_valid (grant_valid)
    );

endmodule

// ==== tests/snp_fwd_sva.sv ====
`timescale 1ns/10ps

module snp_fwd_sva (
    input logic                                clk,
    input logic                                rst,
    input logic                                snp_rsp_valid,
    input logic                                snp_rsp_ready,
    input logic [snp_pkg::addr_width-1:0]      snp_rsp_addr,
    input logic                                snp_rsp_invalidate,
    input logic [snp_pkg::req_tag_width-1:0]   snp_rsp_tag,
    input logic [snp_pkg::num_requests-1:0]    ack_ready,
    input logic [snp_pkg::num_requests-1:0]    fwd_valid
);

    // a held response keeps its data.
    rsp_stable: assert property (@(posedge clk) disable iff (rst)
        snp_rsp_valid && !snp_rsp_ready |=> snp_rsp_valid && $stable(snp_rsp_addr)
        && $stable(snp_rsp_invalidate) && $stable(snp_rsp_tag))
        else $error("response changed while held");

    ack_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack_ready))
        else $error("more than one ack_ready high");

    fwd_all_equal: assert property (@(posedge clk) disable iff (rst)
        fwd_valid == '0 || fwd_valid == '1)
        else $error("fwd_valid bits differ");

endmodule

bind snp_forwarder snp_fwd_sva u_snp_fwd_sva (
    .clk(clk), .rst(rst), .snp_rsp_valid(snp_rsp_valid), .snp_rsp_ready(snp_rsp_ready),
    .snp_rsp_addr(snp_rsp_addr), .snp_rsp_invalidate(snp_rsp_invalidate),
    .snp_rsp_tag(snp_rsp_tag), .ack_ready(ack_ready), .fwd_valid(fwd_valid)
);

// ==== tests/snp_fwd_tests.svh ====
// all tasks start and end 1 ns after a rising edge.
task automatic start_req(input logic [snp_pkg::addr_width-1:0] addr, input logic inv,
                         input logic [snp_pkg::req_tag_width-1:0] tag);
    snp_req_valid = 1'b1;
    snp_req_addr = addr;
    snp_req_invalidate = inv;
    snp_req_tag = tag;
endtask

task automatic finish_req();
    int cycles;
    logic done;
    done = 1'b0;
    cycles = 0;
    while (!done && cycles < wait_limit) begin
        @(posedge clk);
        done = snp_req_ready;
        cycles++;
    end
    #1;
    snp_req_valid = 1'b0;
    assert (done) else begin
        other_errors++;
        $display("timeout: request tag %h was never accepted", snp_req_tag);
    end
endtask

task automatic send_req(input logic [snp_pkg::addr_width-1:0] addr, input logic inv,
                        input logic [snp_pkg::req_tag_width-1:0] tag);
    start_req(addr, inv, tag);
    finish_req();
endtask

task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    while (rsp_count != req_count && cycles < wait_limit) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    assert (rsp_count == req_count) else begin
        other_errors++;
        $display("timeout: %s left %0d snoops without response", what, req_count - rsp_count);
    end
endtask

task automatic single_snoop();
    send_req(26'h2a5_1c3e, 1'b1, 8'h11);
    wait_drained("single snoop");
    repeat (10) @(posedge clk);
    #1;
    assert (rsp_count == 1 && last_rsp_tag == 8'h11 && tag_returned[8'h11] == 1) else begin
        mismatch_errors++;
        $display("Mismatch at %0t: %0d responses, last tag %h", $time, rsp_count, last_rsp_tag);
    end
endtask

task automatic table_full();
    ack_hold = 1'b1;
    for (int i = 0; i < snp_pkg::snrq_size; i++) begin
        send_req(26'h100_0000 + 26'(i * 64), i[0], 8'(8'h20 + i));
    end
    start_req(26'h1ff_ff00, 1'b0, 8'h28);
    repeat (6) begin
        @(posedge clk);
        assert (!snp_req_ready) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: request accepted while table full", $time);
        end
    end
    #1;
    ack_hold = 1'b0;
    finish_req();
    wait_drained("table full");
endtask

task automatic broadcast_stall();
    fwd_ready[2] = 1'b0;
    start_req(26'h033_4455, 1'b0, 8'h30);
    repeat (6) begin
        @(posedge clk);
        assert (!snp_req_ready && fwd_valid == '0) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: request passed a stalled bank", $time);
        end
    end
    #1;
    fwd_ready = '1;
    finish_req();
    wait_drained("broadcast stall");
endtask

task automatic out_of_order();
    int r;
    for (int i = 0; i < 6; i++) begin
        r = lfsr_bits(snp_pkg::addr_width);
        send_req(r[snp_pkg::addr_width-1:0], i[1], 8'(8'h40 + i));
    end
    wait_drained("out of order");
    for (int i = 0; i < 6; i++) begin
        assert (tag_returned[8'h40 + i] == 1) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: tag %h returned %0d times", $time, 8'h40 + i,
                     tag_returned[8'h40 + i]);
        end
    end
endtask

task automatic response_backpressure();
    int cycles;
    int seen;
    seen = rsp_count;
    snp_rsp_ready = 1'b0;
    send_req(26'h3c0_ffee, 1'b1, 8'h55);
    cycles = 0;
    while (!snp_rsp_valid && cycles < wait_limit) begin
        @(posedge clk);
        cycles++;
    end
    assert (snp_rsp_valid) else begin
        other_errors++;
        $display("timeout: held response never became valid");
    end
    repeat (8) begin
        @(posedge clk);
        assert (snp_rsp_valid && snp_rsp_addr == 26'h3c0_ffee && snp_rsp_invalidate
                && snp_rsp_tag == 8'h55) else begin
            mismatch_errors++;
            $display("Mismatch at %0t: held response changed or was lost", $time);
        end
    end
    #1;
    assert (rsp_count == seen) else begin
        mismatch_errors++;
        $display("Mismatch at %0t: response delivered while snp_rsp_ready was low", $time);
    end
    snp_rsp_ready = 1'b1;
    wait_drained("response back-pressure");
    assert (last_rsp_tag == 8'h55) else begin
        mismatch_errors++;
        $display("Mismatch at %0t: last tag %h, expected 55", $time, last_rsp_tag);
    end
endtask

// ==== tests/snp_fwd_tb.sv ====
`timescale 1ns/10ps

module snp_fwd_tb;

    localparam int wait_limit = 600;

    logic clk;
    logic rst;
    logic                                                      snp_req_valid;
    logic [snp_pkg::addr_width-1:0]                            snp_req_addr;
    logic                                                      snp_req_invalidate;
    logic [snp_pkg::req_tag_width-1:0]                         snp_req_tag;
    logic                                                      snp_req_ready;
    logic                                                      snp_rsp_valid;
    logic [snp_pkg::addr_width-1:0]                            snp_rsp_addr;
    logic                                                      snp_rsp_invalidate;
    logic [snp_pkg::req_tag_width-1:0]                         snp_rsp_tag;
    logic                                                      snp_rsp_ready;
    logic [snp_pkg::num_requests-1:0]                          fwd_valid;
    logic [snp_pkg::num_requests-1:0][snp_pkg::addr_width-1:0] fwd_addr;
    logic [snp_pkg::num_requests-1:0]                          fwd_invalidate;
    logic [snp_pkg::num_requests-1:0][snp_pkg::slot_bits-1:0]  fwd_tag;
    logic [snp_pkg::num_requests-1:0]                          fwd_ready;
    logic [snp_pkg::num_requests-1:0]                          ack_valid;
    logic [snp_pkg::num_requests-1:0][snp_pkg::slot_bits-1:0]  ack_tag;
    logic [snp_pkg::num_requests-1:0]                          ack_ready;

    int mismatch_errors;
    int other_errors;
    int req_count;
    int rsp_count;
    logic [31:0] lfsr_state;

    // scoreboard indexed by slot tag.
    logic [snp_pkg::addr_width-1:0]    sb_addr [snp_pkg::snrq_size];
    logic                              sb_inv  [snp_pkg::snrq_size];
    logic [snp_pkg::req_tag_width-1:0] sb_tag  [snp_pkg::snrq_size];
    logic                              sb_busy [snp_pkg::snrq_size];
    int                                sb_acks [snp_pkg::snrq_size];
    int                                tag_returned [256];
    logic [snp_pkg::req_tag_width-1:0] last_rsp_tag;

    // bank model state.
    logic [snp_pkg::snrq_size-1:0]     bank_pend  [snp_pkg::num_requests];
    int                                bank_delay [snp_pkg::num_requests];
    logic [snp_pkg::num_requests-1:0]  ack_taken;
    logic                              ack_hold;

    snp_fwd_top u_snp_fwd_top (.*);

    // 32-bit fibonacci lfsr with taps 32 22 2 1.
    function automatic int lfsr_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic observe_edge();
        int fin_b;
        int exp_slot;
        logic [snp_pkg::slot_bits-1:0] s;
        fin_b = -1;
        // lowest free slot before this edge.
        exp_slot = -1;
        for (int i = snp_pkg::snrq_size - 1; i >= 0; i--) begin
            if (!sb_busy[i]) begin
                exp_slot = i;
            end
        end
        for (int b = 0; b < snp_pkg::num_requests; b++) begin
            ack_taken[b] = ack_valid[b] && ack_ready[b];
            if (ack_taken[b]) begin
                s = ack_tag[b];
                sb_acks[s]++;
                if (sb_acks[s] == snp_pkg::num_requests) begin
                    fin_b = b;
                end
            end
        end
        if (snp_rsp_valid && snp_rsp_ready) begin
            assert (fin_b >= 0) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: response without a fourth ack", $time);
            end
            if (fin_b >= 0) begin
                s = ack_tag[fin_b];
                assert (snp_rsp_addr == sb_addr[s] && snp_rsp_invalidate == sb_inv[s]
                        && snp_rsp_tag == sb_tag[s]) else begin
                    mismatch_errors++;
                    $display("Mismatch at %0t: response %h/%b/%h, expected %h/%b/%h", $time,
                             snp_rsp_addr, snp_rsp_invalidate, snp_rsp_tag,
                             sb_addr[s], sb_inv[s], sb_tag[s]);
                end
                sb_busy[s] = 1'b0;
            end
            tag_returned[snp_rsp_tag]++;
            last_rsp_tag = snp_rsp_tag;
            rsp_count++;
        end else begin
            assert (fin_b < 0) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: final ack accepted without response", $time);
            end
        end
        if (snp_req_valid && snp_req_ready) begin
            assert (exp_slot >= 0) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: request accepted with every slot busy", $time);
            end
            s = exp_slot[snp_pkg::slot_bits-1:0];
            sb_addr[s] = snp_req_addr;
            sb_inv[s]  = snp_req_invalidate;
            sb_tag[s]  = snp_req_tag;
            sb_busy[s] = 1'b1;
            sb_acks[s] = 0;
            req_count++;
            for (int b = 0; b < snp_pkg::num_requests; b++) begin
                assert (fwd_valid[b] && fwd_tag[b] == s && fwd_addr[b] == snp_req_addr
                        && fwd_invalidate[b] == snp_req_invalidate) else begin
                    mismatch_errors++;
                    $display("Mismatch at %0t: bank %0d broadcast wrong", $time, b);
                end
                bank_pend[b][s] = 1'b1;
            end
        end else begin
            assert (fwd_valid == '0) else begin
                mismatch_errors++;
                $display("Mismatch at %0t: fwd_valid %b without request", $time, fwd_valid);
            end
        end
    endtask

    // each bank acks its pending slots in random order after random delays.
    task automatic drive_banks();
        int start;
        int idx;
        for (int b = 0; b < snp_pkg::num_requests; b++) begin
            if (ack_taken[b]) begin
                ack_valid[b] = 1'b0;
            end
            if (!ack_valid[b] && !ack_hold && bank_pend[b] != '0) begin
                if (bank_delay[b] > 0) begin
                    bank_delay[b]--;
                end else begin
                    start = lfsr_bits(3);
                    for (int k = snp_pkg::snrq_size - 1; k >= 0; k--) begin
                        idx = (start + k) % snp_pkg::snrq_size;
                        if (bank_pend[b][idx]) begin
                            ack_tag[b] = idx[snp_pkg::slot_bits-1:0];
                        end
                    end
                    ack_valid[b] = 1'b1;
                    bank_pend[b][ack_tag[b]] = 1'b0;
                    bank_delay[b] = lfsr_bits(3);
                end
            end
        end
    endtask

    always begin
        @(posedge clk);
        if (!rst) begin
            observe_edge();
        end
        #1;
        if (!rst) begin
            drive_banks();
        end
    end

    `include "snp_fwd_tests.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        snp_req_valid = 1'b0;
        snp_req_addr = '0;
        snp_req_invalidate = 1'b0;
        snp_req_tag = '0;
        snp_rsp_ready = 1'b1;
        fwd_ready = '1;
        ack_valid = '0;
        ack_tag = '0;
        ack_taken = '0;
        ack_hold = 1'b0;
        lfsr_state = 32'h07b9_022d;
        mismatch_errors = 0;
        other_errors = 0;
        req_count = 0;
        rsp_count = 0;
        last_rsp_tag = '0;
        for (int i = 0; i < snp_pkg::snrq_size; i++) begin
            sb_busy[i] = 1'b0;
            sb_acks[i] = 0;
        end
        for (int b = 0; b < snp_pkg::num_requests; b++) begin
            bank_pend[b] = '0;
            bank_delay[b] = 0;
        end
        for (int t = 0; t < 256; t++) begin
            tag_returned[t] = 0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        single_snoop();
        table_full();
        broadcast_stall();
        out_of_order();
        response_backpressure();
        $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+tests
hw/snp_pkg.sv
hw/snp_slot_table.sv
hw/snp_ack_arbiter.sv
hw/snp_forwarder.sv
hw/snp_fwd_top.sv
tests/snp_fwd_sva.sv
tests/snp_fwd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the snoop forwarder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module snp_fwd_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vsnp_fwd_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
